/* files.f */
design/afu_pkg.sv
design/req_fifo.sv
design/rr_arbiter.sv
design/queue_copy_afu.sv
design/req_channel.sv
design/afu_manager.sv
dv/afu_manager_tb.sv

/* dv/afu_manager_tb.sv */
`default_nettype none

module afu_manager_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic                    clk;
  logic                    rst;
  logic                    rst_afus;
  logic                    start_afus;
  logic [1:0]              conf_valid;
  afu_pkg::conf_t          conf;
  logic                    req_rd_available;
  logic                    req_rd_en;
  afu_pkg::rd_req_t        req_rd;
  afu_pkg::rd_resp_t       resp_rd;
  logic                    req_wr_available;
  logic                    req_wr_en;
  afu_pkg::wr_req_t        req_wr;
  afu_pkg::wr_resp_t       resp_wr;
  afu_pkg::status_t        info;

  integer                      seed;
  int                          cycle;
  int                          limit;
  int                          run_id;
  logic [afu_pkg::addr_w-1:0]  run_rd_base [2][afu_pkg::num_queues];
  logic [afu_pkg::addr_w-1:0]  run_wr_base [2][afu_pkg::num_queues];
  int                          run_lines   [2][afu_pkg::num_queues];
  int                          rd_seen      [afu_pkg::num_queues];
  int                          rd_resp_sent [afu_pkg::num_queues];
  int                          wr_seen      [afu_pkg::num_queues];
  int                          wr_ack_sent  [afu_pkg::num_queues];
  int                          done_at      [afu_pkg::num_queues];  // -1 until last ack sent
  int                          rd_due     [afu_pkg::num_queues][16];
  int                          resp_cycle [afu_pkg::num_queues][16];
  int                          wr_due     [afu_pkg::num_queues][16];
  int                          rd_low;
  int                          wr_low;
  int                          rd_hold;
  int                          wr_hold;
  int                          rd_next;
  int                          wr_next;
  int                          last_wr_q;
  int                          status_skip;

  afu_manager DUT (
    .clk              (clk),
    .rst              (rst),
    .rst_afus         (rst_afus),
    .start_afus       (start_afus),
    .conf_valid       (conf_valid),
    .conf             (conf),
    .req_rd_available (req_rd_available),
    .req_rd_en        (req_rd_en),
    .req_rd           (req_rd),
    .resp_rd          (resp_rd),
    .req_wr_available (req_wr_available),
    .req_wr_en        (req_wr_en),
    .req_wr           (req_wr),
    .resp_wr          (resp_wr),
    .info             (info)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // ======================================================================
  // helpers and compare tasks
  // ======================================================================
  function automatic int pick_below(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  // memory contents: the address followed by its inverse
  function automatic logic [afu_pkg::data_w-1:0] line_data(input logic [afu_pkg::addr_w-1:0] a);
    return {a, ~a};
  endfunction

  function automatic logic all_done();
    logic d;
    d = 1'b1;
    for (int q = 0; q < afu_pkg::num_queues; q++) begin
      if (done_at[q] < 0 || cycle < done_at[q]) begin
        d = 1'b0;
      end
    end
    return d;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_rd(input afu_pkg::rd_req_t actual, input afu_pkg::rd_req_t expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Error at %0t: req_rd actual %h expected %h",
                                  $time, actual, expected));
    end
  endtask

  task automatic check_wr(input afu_pkg::wr_req_t actual, input afu_pkg::wr_req_t expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Error at %0t: req_wr actual %h expected %h",
                                  $time, actual, expected));
    end
  endtask

  task automatic check_status(input afu_pkg::status_t actual, input afu_pkg::status_t expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Error at %0t: info actual %h expected %h",
                                  $time, actual, expected));
    end
  endtask

  // ======================================================================
  // per-cycle monitors and memory model
  // ======================================================================
  task automatic watch_issues();
    int                q;
    int                k;
    afu_pkg::rd_req_t  exp_rd;
    afu_pkg::wr_req_t  exp_wr;
    if (req_rd_en) begin
      if (rd_low >= 3) begin
        stop_with_failure($sformatf("read enable after %0d cycles of low available", rd_low));
      end
      q = int'(req_rd.tag[afu_pkg::qid_w-1:0]);
      k = rd_seen[q];
      if (k >= run_lines[run_id][q]) begin
        stop_with_failure($sformatf("read beyond the line count of queue %0d", q));
      end
      exp_rd.addr = run_rd_base[run_id][q] + afu_pkg::addr_w'(k);
      exp_rd.tag  = afu_pkg::tag_w'(q);
      check_rd(req_rd, exp_rd);
      rd_due[q][k] = cycle + 1 + pick_below(6);
      rd_seen[q]   = k + 1;
    end
    if (req_wr_en) begin
      if (wr_low >= 3) begin
        stop_with_failure($sformatf("write enable after %0d cycles of low available", wr_low));
      end
      q = int'(req_wr.tag[afu_pkg::qid_w-1:0]);
      k = wr_seen[q];
      if (k >= rd_resp_sent[q]) begin
        stop_with_failure($sformatf("write of queue %0d before its read response", q));
      end
      exp_wr.addr = run_wr_base[run_id][q] + afu_pkg::addr_w'(k);
      exp_wr.data = line_data(run_rd_base[run_id][q] + afu_pkg::addr_w'(k));
      exp_wr.tag  = afu_pkg::tag_w'(q);
      check_wr(req_wr, exp_wr);
      if (q == last_wr_q) begin
        for (int y = 0; y < afu_pkg::num_queues; y++) begin
          // a response needs about five cycles to reach the arbiter
          if (y != q && wr_seen[y] < rd_resp_sent[y] && resp_cycle[y][wr_seen[y]] + 6 <= cycle) begin
            stop_with_failure($sformatf("queue %0d issued twice while queue %0d waited", q, y));
          end
        end
      end
      last_wr_q    = q;
      wr_due[q][k] = cycle + 1 + pick_below(6);
      wr_seen[q]   = k + 1;
    end
  endtask

  task automatic watch_status();
    afu_pkg::status_t exp_info;
    if (status_skip > 0) begin
      status_skip--;
    end else begin
      exp_info.num_rd_queues = 8'd4;
      exp_info.num_wr_queues = 8'd4;
      for (int q = 0; q < afu_pkg::num_queues; q++) begin
        exp_info.done[q] = (done_at[q] >= 0 && cycle >= done_at[q]);
      end
      check_status(info, exp_info);
    end
  endtask

  // one response per bus and cycle, oldest first within a queue
  task automatic drive_memory();
    int   q;
    int   k;
    logic rd_sent;
    logic wr_sent;
    resp_rd = '0;
    resp_wr = '0;
    rd_sent = 1'b0;
    wr_sent = 1'b0;
    for (int i = 0; i < afu_pkg::num_queues; i++) begin
      q = (rd_next + i) % afu_pkg::num_queues;
      k = rd_resp_sent[q];
      if (!rd_sent && k < rd_seen[q] && rd_due[q][k] <= cycle) begin
        resp_rd.valid    = 1'b1;
        resp_rd.data     = line_data(run_rd_base[run_id][q] + afu_pkg::addr_w'(k));
        resp_rd.tag      = afu_pkg::tag_w'(q);
        resp_cycle[q][k] = cycle;
        rd_resp_sent[q]  = k + 1;
        rd_next          = (q + 1) % afu_pkg::num_queues;
        rd_sent          = 1'b1;
      end
    end
    for (int i = 0; i < afu_pkg::num_queues; i++) begin
      q = (wr_next + i) % afu_pkg::num_queues;
      k = wr_ack_sent[q];
      if (!wr_sent && k < wr_seen[q] && wr_due[q][k] <= cycle) begin
        resp_wr.valid  = 1'b1;
        resp_wr.tag    = afu_pkg::tag_w'(q);
        wr_ack_sent[q] = k + 1;
        if (k + 1 == run_lines[run_id][q]) begin
          done_at[q] = cycle + 2;  // engine state, then the status register
        end
        wr_next = (q + 1) % afu_pkg::num_queues;
        wr_sent = 1'b1;
      end
    end
  endtask

  task automatic drive_available();
    if (rd_hold == 0) begin
      req_rd_available = (pick_below(4) != 0);
      rd_hold          = 1 + pick_below(6);
    end
    if (wr_hold == 0) begin
      req_wr_available = (pick_below(4) != 0);
      wr_hold          = 1 + pick_below(6);
    end
    rd_hold--;
    wr_hold--;
  endtask

  task automatic step();
    @(negedge clk);
    cycle++;
    if (cycle > limit) begin
      stop_with_failure($sformatf("timeout after %0d cycles", cycle));
    end
    rd_low = req_rd_available ? 0 : rd_low + 1;  // low cycles already seen by the DUT
    wr_low = req_wr_available ? 0 : wr_low + 1;
    if (!rst) begin
      watch_issues();
      watch_status();
    end
    drive_memory();
    drive_available();
  endtask

  // ======================================================================
  // runs
  // ======================================================================
  task automatic run_copy(input int r);
    run_id    = r;
    last_wr_q = -1;
    for (int q = 0; q < afu_pkg::num_queues; q++) begin
      rd_seen[q]      = 0;
      rd_resp_sent[q] = 0;
      wr_seen[q]      = 0;
      wr_ack_sent[q]  = 0;
      done_at[q]      = -1;
    end
    for (int q = 0; q < afu_pkg::num_queues; q++) begin
      conf.qtd = afu_pkg::qtd_w'(run_lines[r][q]);
      conf.qid = afu_pkg::qid_w'(q);
      conf_valid                   = '0;
      conf_valid[afu_pkg::conf_rd] = 1'b1;
      conf.addr                    = run_rd_base[r][q];
      step();
      conf_valid                   = '0;
      conf_valid[afu_pkg::conf_wr] = 1'b1;
      conf.addr                    = run_wr_base[r][q];
      step();
    end
    conf_valid = '0;
    start_afus = 1'b1;
    step();
    start_afus = 1'b0;
    while (!all_done()) begin
      step();
    end
    repeat (8) step();
  endtask

  initial begin
    int total;
    seed             = 32'h47b;
    rst              = 1'b1;
    rst_afus         = 1'b0;
    start_afus       = 1'b0;
    conf_valid       = '0;
    conf             = '0;
    req_rd_available = 1'b1;
    req_wr_available = 1'b1;
    resp_rd          = '0;
    resp_wr          = '0;
    cycle            = 0;
    run_id           = 0;
    rd_low           = 0;
    wr_low           = 0;
    rd_hold          = 0;
    wr_hold          = 0;
    rd_next          = 0;
    wr_next          = 0;
    last_wr_q        = -1;
    status_skip      = 0;
    total            = 0;
    for (int q = 0; q < afu_pkg::num_queues; q++) begin
      rd_seen[q]      = 0;
      rd_resp_sent[q] = 0;
      wr_seen[q]      = 0;
      wr_ack_sent[q]  = 0;
      done_at[q]      = -1;
    end
    for (int r = 0; r < 2; r++) begin
      for (int q = 0; q < afu_pkg::num_queues; q++) begin
        run_lines[r][q]   = 1 + pick_below(12);
        run_rd_base[r][q] = 32'h1000_0000 + q * 32'h0010_0000 + pick_below(32'h1_0000);
        run_wr_base[r][q] = 32'h2000_0000 + q * 32'h0010_0000 + pick_below(32'h1_0000);
        total             = total + run_lines[r][q];
      end
    end
    limit = 200 + 40 * total;

    repeat (10) step();
    rst = 1'b0;
    step();
    run_copy(0);

    // clear the engine, then run again with fresh geometry
    rst_afus    = 1'b1;
    status_skip = 2;
    for (int q = 0; q < afu_pkg::num_queues; q++) begin
      done_at[q] = -1;
    end
    step();
    rst_afus = 1'b0;
    run_copy(1);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* design/afu_manager.sv */
`default_nettype none

module afu_manager (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rst_afus,
  input  logic                 start_afus,
  input  logic [1:0]           conf_valid,
  input  afu_pkg::conf_t       conf,
  input  logic                 req_rd_available,
  output logic                 req_rd_en,
  output afu_pkg::rd_req_t     req_rd,
  input  afu_pkg::rd_resp_t    resp_rd,
  input  logic                 req_wr_available,
  output logic                 req_wr_en,
  output afu_pkg::wr_req_t     req_wr,
  input  afu_pkg::wr_resp_t    resp_wr,
  output afu_pkg::status_t     info
);

  logic                               eng_rst;
  logic [afu_pkg::num_queues-1:0]     rd_push;
  logic [afu_pkg::num_queues-1:0]     wr_push;
  logic [afu_pkg::num_queues-1:0]     rd_almost_full;
  logic [afu_pkg::num_queues-1:0]     wr_almost_full;
  logic [afu_pkg::num_queues-1:0]     done;
  afu_pkg::rd_req_t                   rd_entry [afu_pkg::num_queues];
  afu_pkg::wr_req_t                   wr_entry [afu_pkg::num_queues];
  logic [afu_pkg::fifo_depth_bits:0]  wr_count [afu_pkg::num_queues];

  assign eng_rst = rst | rst_afus;  // rst_afus clears the queues but not the channels

  // ======================================================================
  // copy engine and request channels
  // ======================================================================
  queue_copy_afu u_engine (
    .clk            (clk),
    .rst            (eng_rst),
    .start          (start_afus),
    .conf_valid     (conf_valid),
    .conf           (conf),
    .rd_push        (rd_push),
    .rd_entry       (rd_entry),
    .wr_push        (wr_push),
    .wr_entry       (wr_entry),
    .rd_almost_full (rd_almost_full),
    .wr_almost_full (wr_almost_full),
    .wr_count       (wr_count),
    .resp_rd        (resp_rd),
    .resp_wr        (resp_wr),
    .done           (done)
  );

  req_channel #(
    .entry_t(afu_pkg::rd_req_t)
  ) u_rd_chan (
    .clk         (clk),
    .rst         (rst),
    .push        (rd_push),
    .entry       (rd_entry),
    .almost_full (rd_almost_full),
    .count       (),
    .available   (req_rd_available),
    .issue_en    (req_rd_en),
    .issue       (req_rd)
  );

  req_channel #(
    .entry_t(afu_pkg::wr_req_t)
  ) u_wr_chan (
    .clk         (clk),
    .rst         (rst),
    .push        (wr_push),
    .entry       (wr_entry),
    .almost_full (wr_almost_full),
    .count       (wr_count),
    .available   (req_wr_available),
    .issue_en    (req_wr_en),
    .issue       (req_wr)
  );

  // status word lags the done mask by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      info <= '0;
    end else begin
      info.num_rd_queues <= 8'(afu_pkg::num_queues);
      info.num_wr_queues <= 8'(afu_pkg::num_queues);
      info.done          <= done;
    end
  end

endmodule

`default_nettype wire

/* design/req_channel.sv */
`default_nettype none

module req_channel #(
  parameter type entry_t = afu_pkg::rd_req_t
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [afu_pkg::num_queues-1:0]      push,
  input  entry_t                              entry [afu_pkg::num_queues],
  output logic [afu_pkg::num_queues-1:0]      almost_full,
  output logic [afu_pkg::fifo_depth_bits:0]   count [afu_pkg::num_queues],
  input  logic                                available,
  output logic                                issue_en,
  output entry_t                              issue
);

  afu_pkg::chan_state_t             state;
  logic [afu_pkg::num_queues-1:0]   empty;
  logic [afu_pkg::num_queues-1:0]   pop;
  logic [afu_pkg::num_queues-1:0]   fifo_valid;
  logic [afu_pkg::num_queues-1:0]   arb_request;
  logic [afu_pkg::num_queues-1:0]   grant;
  logic                             grant_valid;
  entry_t                           fifo_dout [afu_pkg::num_queues];
  entry_t                           popped;

  // ======================================================================
  // per-queue FIFOs and arbiter
  // ======================================================================
  for (genvar q = 0; q < afu_pkg::num_queues; q++) begin : gen_fifo
    req_fifo #(
      .entry_t(entry_t)
    ) u_fifo (
      .clk         (clk),
      .rst         (rst),
      .we          (push[q]),
      .din         (entry[q]),
      .re          (pop[q]),
      .valid       (fifo_valid[q]),
      .dout        (fifo_dout[q]),
      .count       (count[q]),
      .empty       (empty[q]),
      .almost_full (almost_full[q])
    );
  end

  rr_arbiter u_arb (
    .clk         (clk),
    .rst         (rst),
    .request     (arb_request),
    .grant       (grant),
    .grant_valid (grant_valid)
  );

  // only one arbitration is in flight at a time, so every grant is used
  assign arb_request = (state == afu_pkg::chan_idle && available && !grant_valid) ?
                       ~empty : '0;
  assign pop         = (state == afu_pkg::chan_idle && grant_valid) ? grant : '0;

  // at most one FIFO answers a pop
  always_comb begin
    popped = fifo_dout[0];
    for (int q = 1; q < afu_pkg::num_queues; q++) begin
      if (fifo_valid[q]) begin
        popped = fifo_dout[q];
      end
    end
  end

  // ======================================================================
  // pop FSM and issue register
  // ======================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= afu_pkg::chan_idle;
    end else begin
      case (state)
        afu_pkg::chan_idle: begin
          if (grant_valid) begin
            state <= afu_pkg::chan_wait;
          end
        end
        afu_pkg::chan_wait: begin
          if (|fifo_valid) begin
            state <= afu_pkg::chan_idle;
          end
        end
        default: state <= afu_pkg::chan_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      issue_en <= 1'b0;
    end else begin
      issue_en <= |fifo_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (|fifo_valid) begin
      issue <= popped;
    end
  end

endmodule

`default_nettype wire

/* design/queue_copy_afu.sv */
`default_nettype none

module queue_copy_afu (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                start,
  input  logic [1:0]                          conf_valid,
  input  afu_pkg::conf_t                      conf,
  output logic [afu_pkg::num_queues-1:0]      rd_push,
  output afu_pkg::rd_req_t                    rd_entry [afu_pkg::num_queues],
  output logic [afu_pkg::num_queues-1:0]      wr_push,
  output afu_pkg::wr_req_t                    wr_entry [afu_pkg::num_queues],
  input  logic [afu_pkg::num_queues-1:0]      rd_almost_full,
  input  logic [afu_pkg::num_queues-1:0]      wr_almost_full,
  input  logic [afu_pkg::fifo_depth_bits:0]   wr_count [afu_pkg::num_queues],
  input  afu_pkg::rd_resp_t                   resp_rd,
  input  afu_pkg::wr_resp_t                   resp_wr,
  output logic [afu_pkg::num_queues-1:0]      done
);

  afu_pkg::queue_state_t               state       [afu_pkg::num_queues];
  logic [afu_pkg::addr_w-1:0]          rd_base     [afu_pkg::num_queues];
  logic [afu_pkg::addr_w-1:0]          wr_base     [afu_pkg::num_queues];
  logic [afu_pkg::qtd_w-1:0]           rd_qtd      [afu_pkg::num_queues];
  logic [afu_pkg::qtd_w-1:0]           wr_qtd      [afu_pkg::num_queues];
  logic [afu_pkg::qtd_w-1:0]           rd_issued   [afu_pkg::num_queues];
  logic [afu_pkg::qtd_w-1:0]           wr_index    [afu_pkg::num_queues];
  logic [afu_pkg::qtd_w-1:0]           wr_acked    [afu_pkg::num_queues];
  logic [afu_pkg::fifo_depth_bits:0]   outstanding [afu_pkg::num_queues];
  logic [afu_pkg::num_queues-1:0]      rd_cfg;
  logic [afu_pkg::num_queues-1:0]      wr_cfg;
  logic [afu_pkg::num_queues-1:0]      rd_go;
  logic [afu_pkg::num_queues-1:0]      rd_hit;
  logic [afu_pkg::num_queues-1:0]      wr_hit;
  logic [afu_pkg::qid_w-1:0]           rd_resp_q;
  logic [afu_pkg::qid_w-1:0]           wr_resp_q;

  assign rd_resp_q = resp_rd.tag[afu_pkg::qid_w-1:0];
  assign wr_resp_q = resp_wr.tag[afu_pkg::qid_w-1:0];

  // ======================================================================
  // configuration
  // ======================================================================
  always_ff @(posedge clk) begin
    if (conf_valid[afu_pkg::conf_rd]) begin
      rd_base[conf.qid] <= conf.addr;
      rd_qtd[conf.qid]  <= conf.qtd;
    end
    if (conf_valid[afu_pkg::conf_wr]) begin
      wr_base[conf.qid] <= conf.addr;
      wr_qtd[conf.qid]  <= conf.qtd;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_cfg <= '0;
      wr_cfg <= '0;
    end else begin
      if (conf_valid[afu_pkg::conf_rd]) begin
        rd_cfg[conf.qid] <= 1'b1;
      end
      if (conf_valid[afu_pkg::conf_wr]) begin
        wr_cfg[conf.qid] <= 1'b1;
      end
    end
  end

  // ======================================================================
  // read issue and response routing
  // ======================================================================
  // outstanding covers reads not yet turned into a write push, so together
  // with wr_count it bounds what can still land in the write FIFO
  always_comb begin
    for (int q = 0; q < afu_pkg::num_queues; q++) begin
      rd_hit[q] = resp_rd.valid && (rd_resp_q == afu_pkg::qid_w'(q));
      wr_hit[q] = resp_wr.valid && (wr_resp_q == afu_pkg::qid_w'(q));
      rd_go[q]  = (state[q] == afu_pkg::q_run) && (rd_issued[q] != rd_qtd[q]) &&
                  !rd_almost_full[q] && !wr_almost_full[q] &&
                  (int'(outstanding[q]) + int'(wr_count[q]) < afu_pkg::fifo_depth);
      done[q]   = (state[q] == afu_pkg::q_done);
    end
  end

  always_ff @(posedge clk) begin
    for (int q = 0; q < afu_pkg::num_queues; q++) begin
      if (rd_go[q]) begin
        rd_entry[q].addr <= rd_base[q] + afu_pkg::addr_w'(rd_issued[q]);
        rd_entry[q].tag  <= afu_pkg::tag_w'(q);
      end
      if (rd_hit[q]) begin
        wr_entry[q].addr <= wr_base[q] + afu_pkg::addr_w'(wr_index[q]);
        wr_entry[q].data <= resp_rd.data;
        wr_entry[q].tag  <= afu_pkg::tag_w'(q);
      end
    end
  end

  // ======================================================================
  // per-queue counters and state
  // ======================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_push <= '0;
      wr_push <= '0;
      for (int q = 0; q < afu_pkg::num_queues; q++) begin
        state[q]       <= afu_pkg::q_idle;
        rd_issued[q]   <= '0;
        wr_index[q]    <= '0;
        wr_acked[q]    <= '0;
        outstanding[q] <= '0;
      end
    end else begin
      rd_push <= rd_go;
      wr_push <= rd_hit;
      for (int q = 0; q < afu_pkg::num_queues; q++) begin
        if (rd_go[q]) begin
          rd_issued[q] <= rd_issued[q] + 1'b1;
        end
        if (rd_hit[q]) begin
          wr_index[q] <= wr_index[q] + 1'b1;
        end
        case ({rd_go[q], wr_push[q]})
          2'b10:   outstanding[q] <= outstanding[q] + 1'b1;
          2'b01:   outstanding[q] <= outstanding[q] - 1'b1;
          default: outstanding[q] <= outstanding[q];
        endcase
        case (state[q])
          afu_pkg::q_idle: begin
            if (start && rd_cfg[q] && wr_cfg[q]) begin
              state[q] <= (wr_qtd[q] == '0) ? afu_pkg::q_done : afu_pkg::q_run;
            end
          end
          afu_pkg::q_run: begin
            if (wr_hit[q]) begin
              wr_acked[q] <= wr_acked[q] + 1'b1;
              if (wr_acked[q] + 1'b1 == wr_qtd[q]) begin
                state[q] <= afu_pkg::q_done;  // last write acknowledged
              end
            end
          end
          default: state[q] <= state[q];
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* design/rr_arbiter.sv */
`default_nettype none

module rr_arbiter (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [afu_pkg::num_queues-1:0]  request,
  output logic [afu_pkg::num_queues-1:0]  grant,
  output logic                            grant_valid
);

  logic [afu_pkg::qid_w-1:0] ptr;
  logic [afu_pkg::qid_w-1:0] idx;
  logic [afu_pkg::qid_w-1:0] sel;
  logic                      found;

  // search starts at ptr and wraps, so the last winner is checked last
  always_comb begin
    found = 1'b0;
    sel   = ptr;
    idx   = ptr;
    for (int i = 0; i < afu_pkg::num_queues; i++) begin
      idx = ptr + afu_pkg::qid_w'(i);
      if (!found && request[idx]) begin
        found = 1'b1;
        sel   = idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      grant       <= '0;
      grant_valid <= 1'b0;
      ptr         <= '0;
    end else begin
      grant_valid <= found;
      grant       <= '0;
      if (found) begin
        grant[sel] <= 1'b1;
        ptr        <= sel + 1'b1;  // next search begins just past the winner
      end
    end
  end

endmodule

`default_nettype wire

/* design/req_fifo.sv */
`default_nettype none

module req_fifo #(
  parameter type entry_t = afu_pkg::rd_req_t
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                we,
  input  entry_t                              din,
  input  logic                                re,
  output logic                                valid,
  output entry_t                              dout,
  output logic [afu_pkg::fifo_depth_bits:0]   count,
  output logic                                empty,
  output logic                                almost_full
);

  entry_t                               mem [afu_pkg::fifo_depth];
  logic [afu_pkg::fifo_depth_bits-1:0]  wr_ptr;
  logic [afu_pkg::fifo_depth_bits-1:0]  rd_ptr;
  logic                                 do_wr;
  logic                                 do_rd;

  assign empty       = (count == '0);
  assign almost_full = (count >= afu_pkg::fifo_almost_full);
  assign do_wr       = we && (count != afu_pkg::fifo_depth);  // a push into a full FIFO is dropped
  assign do_rd       = re && !empty;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
    if (do_rd) begin
      dout <= mem[rd_ptr];  // read data lands together with valid
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      valid  <= 1'b0;
    end else begin
      valid <= do_rd;
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/afu_pkg.sv */
`default_nettype none

package afu_pkg;

  // ======================================================================
  // widths and counts
  // ======================================================================
  localparam int addr_w           = 32;
  localparam int data_w           = 64;
  localparam int tag_w            = 8;   // low qid_w bits carry the queue id
  localparam int qtd_w            = 16;
  localparam int num_queues       = 4;
  localparam int qid_w            = 2;
  localparam int fifo_depth_bits  = 3;
  localparam int fifo_depth       = 8;
  localparam int fifo_almost_full = 6;   // two slots of slack for pushes in flight

  // ======================================================================
  // types
  // ======================================================================
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [qtd_w-1:0]  qtd;
    logic [qid_w-1:0]  qid;
  } conf_t;

  // bit positions inside conf_valid
  typedef enum logic {
    conf_rd = 1'b0,
    conf_wr = 1'b1
  } conf_sel_t;

  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [tag_w-1:0]  tag;
  } rd_req_t;

  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
    logic [tag_w-1:0]  tag;
  } wr_req_t;

  typedef struct packed {
    logic              valid;
    logic [data_w-1:0] data;
    logic [tag_w-1:0]  tag;
  } rd_resp_t;

  typedef struct packed {
    logic             valid;
    logic [tag_w-1:0] tag;
  } wr_resp_t;

  typedef struct packed {
    logic [7:0]            num_rd_queues;
    logic [7:0]            num_wr_queues;
    logic [num_queues-1:0] done;
  } status_t;

  typedef enum logic {
    chan_idle,
    chan_wait
  } chan_state_t;

  typedef enum logic [1:0] {
    q_idle,
    q_run,
    q_done
  } queue_state_t;

endpackage

`default_nettype wire
